//--- Bender.yml
package:
  name: core_ctrl

sources:
  - files:
      - src/rv32Pkg.sv
      - src/coreCtrlPkg.sv
      - src/pipeCtrlIf.sv
      - src/instDecoder.sv
      - src/hazardUnit.sv
      - src/ctrlPipe.sv
      - src/coreCtrl.sv
  - target: test
    files:
      - verif/coreCtrl_checker.sv
      - verif/coreCtrlTb.sv

//--- src/coreCtrl.sv
module coreCtrl (
    input  logic                            Clock,
    input  logic                            rstN,
    input  logic [rv32Pkg::XLEN-1:0]        PreInstructionQ101H,
    input  logic                            BranchCondMetQ102H,
    input  logic                            DMemReady,
    // Readies and decode
    output logic                            ReadyQ100H,
    output logic                            ReadyQ101H,
    output logic                            ReadyQ102H,
    output logic [rv32Pkg::RegAddrW-1:0]    RegSrc1Q101H,
    output logic [rv32Pkg::RegAddrW-1:0]    RegSrc2Q101H,
    output logic [rv32Pkg::XLEN-1:0]        ImmediateQ101H,
    // Q102
    output logic                            SelNextPcAluOutQ102H,
    output rv32Pkg::tAluOp                  AluOpQ102H,
    output rv32Pkg::tBranchOp               BranchOpQ102H,
    output logic                            LuiQ102H,
    output logic                            SelAluPcQ102H,
    output logic                            SelAluImmQ102H,
    // Q103
    output logic                            DMemWrEnQ103H,
    output logic                            DMemRdEnQ103H,
    output logic [3:0]                      DMemByteEnQ103H,
    output logic                            SignExtQ103H,
    // Q105
    output coreCtrlPkg::tWbSel              SelWrBackQ105H,
    output logic [rv32Pkg::RegAddrW-1:0]    RegDstQ105H,
    output logic                            RegWrEnQ105H,
    output logic                            ValidInstQ105H
);
    import coreCtrlPkg::*;

    tCtrl ctrlQ101H;
    logic insertNopQ101H;

    pipeCtrlIf pipeIf ();

    hazardUnit uHazard (
        .Clock                (Clock),
        .rstN                 (rstN),
        .PreInstructionQ101H  (PreInstructionQ101H),
        .BranchCondMetQ102H   (BranchCondMetQ102H),
        .DMemReady            (DMemReady),
        .pipeIf               (pipeIf.hazard),
        .InsertNop            (insertNopQ101H),
        .ReadyQ100H           (ReadyQ100H),
        .ReadyQ101H           (ReadyQ101H),
        .SelNextPcAluOutQ102H (SelNextPcAluOutQ102H)
    );

    instDecoder uDecoder (
        .PreInstructionQ101H (PreInstructionQ101H),
        .InsertNop           (insertNopQ101H),
        .CtrlQ101H           (ctrlQ101H),
        .ImmediateQ101H      (ImmediateQ101H)
    );

    ctrlPipe uPipe (
        .Clock           (Clock),
        .rstN            (rstN),
        .CtrlQ101H       (ctrlQ101H),
        .pipeIf          (pipeIf.pipe),
        .AluOpQ102H      (AluOpQ102H),
        .BranchOpQ102H   (BranchOpQ102H),
        .LuiQ102H        (LuiQ102H),
        .SelAluPcQ102H   (SelAluPcQ102H),
        .SelAluImmQ102H  (SelAluImmQ102H),
        .DMemWrEnQ103H   (DMemWrEnQ103H),
        .DMemRdEnQ103H   (DMemRdEnQ103H),
        .DMemByteEnQ103H (DMemByteEnQ103H),
        .SignExtQ103H    (SignExtQ103H),
        .SelWrBackQ105H  (SelWrBackQ105H),
        .RegDstQ105H     (RegDstQ105H),
        .RegWrEnQ105H    (RegWrEnQ105H),
        .ValidInstQ105H  (ValidInstQ105H)
    );

    // Q102..Q105 share the advance
    assign ReadyQ102H   = pipeIf.Advance;
    assign RegSrc1Q101H = ctrlQ101H.RegSrc1;   // Register file read ports
    assign RegSrc2Q101H = ctrlQ101H.RegSrc2;

endmodule

//--- src/coreCtrlPkg.sv
package coreCtrlPkg;

    // Control stages after decode (Q102 to Q105)
    localparam int CtrlStages = 4;

    // Write-back source
    typedef enum logic [1:0] {
        WB_ALU, WB_DMEM, WB_PC4
    } tWbSel;

    // Data memory byte enables
    localparam logic [3:0] ByteEnB = 4'b0001;
    localparam logic [3:0] ByteEnH = 4'b0011;
    localparam logic [3:0] ByteEnW = 4'b1111;

    // Decoded control record, carried down the pipe
    typedef struct packed {
        rv32Pkg::tOpcode                Opcode;
        logic [rv32Pkg::RegAddrW-1:0]   RegDst;
        logic [rv32Pkg::RegAddrW-1:0]   RegSrc1;
        logic [rv32Pkg::RegAddrW-1:0]   RegSrc2;
        rv32Pkg::tAluOp                 AluOp;
        rv32Pkg::tBranchOp              BranchOp;
        logic                           Lui;
        logic                           SelAluPc;     // ALU operand A is PC
        logic                           SelAluImm;    // ALU operand B is immediate
        logic                           SelNextPcB;
        logic                           SelNextPcJ;
        logic                           RegWrEn;
        logic                           DMemWrEn;
        logic                           DMemRdEn;
        logic [3:0]                     DMemByteEn;
        logic                           SignExt;
        tWbSel                          SelWrBack;
    } tCtrl;

endpackage

//--- src/ctrlPipe.sv
module ctrlPipe (
    input  logic                            Clock,
    input  logic                            rstN,
    input  coreCtrlPkg::tCtrl               CtrlQ101H,
    pipeCtrlIf.pipe                         pipeIf,
    // Q102 execute
    output rv32Pkg::tAluOp                  AluOpQ102H,
    output rv32Pkg::tBranchOp               BranchOpQ102H,
    output logic                            LuiQ102H,
    output logic                            SelAluPcQ102H,
    output logic                            SelAluImmQ102H,
    // Q103 memory
    output logic                            DMemWrEnQ103H,
    output logic                            DMemRdEnQ103H,
    output logic [3:0]                      DMemByteEnQ103H,
    output logic                            SignExtQ103H,
    // Q105 write-back
    output coreCtrlPkg::tWbSel              SelWrBackQ105H,
    output logic [rv32Pkg::RegAddrW-1:0]    RegDstQ105H,
    output logic                            RegWrEnQ105H,
    output logic                            ValidInstQ105H
);
    import rv32Pkg::*;
    import coreCtrlPkg::*;

    // Index 0 is Q102 and the last is Q105
    tCtrl                  ctrlQ [CtrlStages];
    logic [CtrlStages-1:0] validQ;

    // Valid bits shift in with the stage record
    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            validQ <= '0;
        end else if (pipeIf.Advance) begin
            validQ <= {validQ[CtrlStages-2:0], pipeIf.ValidInstQ101H};
        end
    end

    always_ff @(posedge Clock) begin
        if (pipeIf.Advance) begin
            ctrlQ[0] <= CtrlQ101H;
            for (int i = 1; i < CtrlStages; i++) begin
                ctrlQ[i] <= ctrlQ[i-1];
            end
        end
    end

    // ----------------------------------------
    // Status for the hazard unit
    // ----------------------------------------
    assign pipeIf.ValidQ102      = validQ[0];
    assign pipeIf.ValidQ103      = validQ[1];
    assign pipeIf.LoadDstQ102    = ctrlQ[0].RegDst;
    assign pipeIf.LoadDstQ103    = ctrlQ[1].RegDst;
    assign pipeIf.IsLoadQ102     = (ctrlQ[0].Opcode == LOAD);
    assign pipeIf.IsLoadQ103     = (ctrlQ[1].Opcode == LOAD);
    assign pipeIf.SelNextPcBQ102 = ctrlQ[0].SelNextPcB;
    assign pipeIf.SelNextPcJQ102 = ctrlQ[0].SelNextPcJ;

    // Stage outputs
    assign AluOpQ102H      = ctrlQ[0].AluOp;
    assign BranchOpQ102H   = ctrlQ[0].BranchOp;
    assign LuiQ102H        = ctrlQ[0].Lui;
    assign SelAluPcQ102H   = ctrlQ[0].SelAluPc;
    assign SelAluImmQ102H  = ctrlQ[0].SelAluImm;
    assign DMemWrEnQ103H   = ctrlQ[1].DMemWrEn && validQ[1];   // No store from a bubble
    assign DMemRdEnQ103H   = ctrlQ[1].DMemRdEn;
    assign DMemByteEnQ103H = ctrlQ[1].DMemByteEn;
    assign SignExtQ103H    = ctrlQ[1].SignExt;
    assign SelWrBackQ105H  = ctrlQ[CtrlStages-1].SelWrBack;
    assign RegDstQ105H     = ctrlQ[CtrlStages-1].RegDst;
    assign RegWrEnQ105H    = ctrlQ[CtrlStages-1].RegWrEn && validQ[CtrlStages-1];
    assign ValidInstQ105H  = validQ[CtrlStages-1];

endmodule

//--- src/hazardUnit.sv
module hazardUnit (
    input  logic                        Clock,
    input  logic                        rstN,
    input  logic [rv32Pkg::XLEN-1:0]    PreInstructionQ101H,
    input  logic                        BranchCondMetQ102H,
    input  logic                        DMemReady,
    pipeCtrlIf.hazard                   pipeIf,
    output logic                        InsertNop,
    output logic                        ReadyQ100H,
    output logic                        ReadyQ101H,
    output logic                        SelNextPcAluOutQ102H
);
    import rv32Pkg::*;

    logic [RegAddrW-1:0] preRegSrc1Q101H;
    logic [RegAddrW-1:0] preRegSrc2Q101H;
    tOpcode              preOpcodeQ101H;
    logic                usesRs2Q101H;
    logic                hazardQ102H;
    logic                hazardQ103H;
    logic                loadHazardQ101H;
    logic                flushQ102H;
    logic                flushQ103H;
    logic                flushAny;

    // Pipe steps whenever data memory is ready
    assign pipeIf.Advance = DMemReady;

    // ----------------------------------------
    // Load-use detection on the raw fetch word
    // ----------------------------------------
    assign preRegSrc1Q101H = PreInstructionQ101H[Rs1Lsb +: RegAddrW];
    assign preRegSrc2Q101H = PreInstructionQ101H[Rs2Lsb +: RegAddrW];
    assign preOpcodeQ101H  = tOpcode'(PreInstructionQ101H[6:0]);
    assign usesRs2Q101H    = (preOpcodeQ101H == R_OP) || (preOpcodeQ101H == STORE)
                          || (preOpcodeQ101H == BRANCH);

    assign hazardQ102H = pipeIf.ValidQ102 && pipeIf.IsLoadQ102
                      && ((pipeIf.LoadDstQ102 == preRegSrc1Q101H)
                      ||  (usesRs2Q101H && pipeIf.LoadDstQ102 == preRegSrc2Q101H));
    assign hazardQ103H = pipeIf.ValidQ103 && pipeIf.IsLoadQ103
                      && ((pipeIf.LoadDstQ103 == preRegSrc1Q101H)
                      ||  (usesRs2Q101H && pipeIf.LoadDstQ103 == preRegSrc2Q101H));
    assign loadHazardQ101H = hazardQ102H || hazardQ103H;

    // ----------------------------------------
    // Flush on taken branch or jump in Q102
    // ----------------------------------------
    assign flushQ102H = pipeIf.ValidQ102
                     && (pipeIf.SelNextPcJQ102 || (pipeIf.SelNextPcBQ102 && BranchCondMetQ102H));
    assign SelNextPcAluOutQ102H = flushQ102H;

    // Second flushed slot; holds through a freeze
    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            flushQ103H <= 1'b0;
        end else if (pipeIf.Advance) begin
            flushQ103H <= flushQ102H;
        end
    end

    assign flushAny  = flushQ102H || flushQ103H;
    assign InsertNop = flushAny || loadHazardQ101H;

    // Flush wins over stall since the stalled word is dropped anyway
    assign ReadyQ101H = pipeIf.Advance && (flushAny || !loadHazardQ101H);
    assign ReadyQ100H = ReadyQ101H;             // Fetch holds with decode
    assign pipeIf.ValidInstQ101H = ReadyQ101H && !InsertNop;

endmodule

//--- src/instDecoder.sv
module instDecoder (
    input  logic [rv32Pkg::XLEN-1:0]    PreInstructionQ101H,
    input  logic                        InsertNop,
    output coreCtrlPkg::tCtrl           CtrlQ101H,
    output logic [rv32Pkg::XLEN-1:0]    ImmediateQ101H
);
    import rv32Pkg::*;
    import coreCtrlPkg::*;

    logic [XLEN-1:0] instQ101H;
    tOpcode          opcodeQ101H;
    logic [2:0]      funct3Q101H;
    logic            altOpQ101H;
    logic            isMemQ101H;
    logic            isJumpQ101H;
    tAluOp           aluOpQ101H;
    tImmType         immTypeQ101H;

    // Bubble replaces the fetched word on stall or flush
    assign instQ101H   = InsertNop ? NopInst : PreInstructionQ101H;
    assign opcodeQ101H = tOpcode'(instQ101H[6:0]);
    assign funct3Q101H = instQ101H[Funct3Lsb +: 3];
    assign altOpQ101H  = instQ101H[Funct7Lsb + 5];   // funct7[5] picks SUB / SRA
    assign isMemQ101H  = (opcodeQ101H == LOAD) || (opcodeQ101H == STORE);
    assign isJumpQ101H = (opcodeQ101H == JAL) || (opcodeQ101H == JALR);

    // ----------------------------------------
    // ALU operation
    // ----------------------------------------
    always_comb begin
        aluOpQ101H = ADD;   // Address and PC math
        if ((opcodeQ101H == R_OP) || (opcodeQ101H == I_OP)) begin
            case (funct3Q101H)
                3'b000:  aluOpQ101H = (opcodeQ101H == R_OP && altOpQ101H) ? SUB : ADD;
                3'b001:  aluOpQ101H = SLL;
                3'b010:  aluOpQ101H = SLT;
                3'b011:  aluOpQ101H = SLTU;
                3'b100:  aluOpQ101H = XOR;
                3'b101:  aluOpQ101H = altOpQ101H ? SRA : SRL;   // Also for SRAI
                3'b110:  aluOpQ101H = OR;
                default: aluOpQ101H = AND;
            endcase
        end
    end

    // ----------------------------------------
    // Control record
    // ----------------------------------------
    always_comb begin
        CtrlQ101H.Opcode     = opcodeQ101H;
        CtrlQ101H.RegDst     = instQ101H[RdLsb +: RegAddrW];
        CtrlQ101H.RegSrc1    = instQ101H[Rs1Lsb +: RegAddrW];
        CtrlQ101H.RegSrc2    = instQ101H[Rs2Lsb +: RegAddrW];
        CtrlQ101H.AluOp      = aluOpQ101H;
        CtrlQ101H.BranchOp   = tBranchOp'(funct3Q101H);
        CtrlQ101H.Lui        = (opcodeQ101H == LUI);
        CtrlQ101H.SelAluPc   = (opcodeQ101H == JAL) || (opcodeQ101H == BRANCH)
                            || (opcodeQ101H == AUIPC);
        CtrlQ101H.SelAluImm  = (opcodeQ101H != R_OP);    // Only reg-reg uses rs2
        CtrlQ101H.SelNextPcB = (opcodeQ101H == BRANCH);
        CtrlQ101H.SelNextPcJ = isJumpQ101H;
        CtrlQ101H.RegWrEn    = (opcodeQ101H == LUI) || (opcodeQ101H == AUIPC) || isJumpQ101H
                            || (opcodeQ101H == LOAD) || (opcodeQ101H == I_OP)
                            || (opcodeQ101H == R_OP);
        CtrlQ101H.DMemWrEn   = (opcodeQ101H == STORE);
        CtrlQ101H.DMemRdEn   = (opcodeQ101H == LOAD);
        CtrlQ101H.SignExt    = (opcodeQ101H == LOAD) && (funct3Q101H[2:1] == 2'b00);  // LB / LH

        CtrlQ101H.DMemByteEn = '0;
        if (isMemQ101H) begin
            case (funct3Q101H[1:0])
                2'b00:   CtrlQ101H.DMemByteEn = ByteEnB;
                2'b01:   CtrlQ101H.DMemByteEn = ByteEnH;
                2'b10:   CtrlQ101H.DMemByteEn = ByteEnW;
                default: CtrlQ101H.DMemByteEn = '0;   // Reserved size
            endcase
        end

        if (isJumpQ101H) begin
            CtrlQ101H.SelWrBack = WB_PC4;             // Link address
        end else if (opcodeQ101H == LOAD) begin
            CtrlQ101H.SelWrBack = WB_DMEM;
        end else begin
            CtrlQ101H.SelWrBack = WB_ALU;
        end
    end

    // ----------------------------------------
    // Immediate generation
    // ----------------------------------------
    always_comb begin
        case (opcodeQ101H)
            JALR, I_OP, LOAD: immTypeQ101H = I_TYPE;
            STORE:            immTypeQ101H = S_TYPE;
            BRANCH:           immTypeQ101H = B_TYPE;
            LUI, AUIPC:       immTypeQ101H = U_TYPE;
            JAL:              immTypeQ101H = J_TYPE;
            default:          immTypeQ101H = I_TYPE;
        endcase

        case (immTypeQ101H)
            S_TYPE: ImmediateQ101H = {{20{instQ101H[31]}}, instQ101H[31:25],
                                      instQ101H[11:7]};
            B_TYPE: ImmediateQ101H = {{20{instQ101H[31]}}, instQ101H[7], instQ101H[30:25],
                                      instQ101H[11:8], 1'b0};
            U_TYPE: ImmediateQ101H = {instQ101H[31:12], 12'b0};
            J_TYPE: ImmediateQ101H = {{12{instQ101H[31]}}, instQ101H[19:12], instQ101H[20],
                                      instQ101H[30:21], 1'b0};
            default: ImmediateQ101H = {{20{instQ101H[31]}}, instQ101H[31:20]};  // I_TYPE
        endcase
    end

endmodule

//--- src/pipeCtrlIf.sv
interface pipeCtrlIf;

    // Hazard unit to pipe
    logic                           Advance;          // All of Q102..Q105 step
    logic                           ValidInstQ101H;   // Valid bit entering Q102

    // Pipe status back to hazard unit
    logic                           ValidQ102;
    logic                           ValidQ103;
    logic [rv32Pkg::RegAddrW-1:0]   LoadDstQ102;
    logic [rv32Pkg::RegAddrW-1:0]   LoadDstQ103;
    logic                           IsLoadQ102;
    logic                           IsLoadQ103;
    logic                           SelNextPcBQ102;   // Branch in Q102
    logic                           SelNextPcJQ102;   // Jump in Q102

    modport hazard (
        output Advance, ValidInstQ101H,
        input  ValidQ102, ValidQ103, LoadDstQ102, LoadDstQ103,
        input  IsLoadQ102, IsLoadQ103, SelNextPcBQ102, SelNextPcJQ102
    );

    modport pipe (
        input  Advance, ValidInstQ101H,
        output ValidQ102, ValidQ103, LoadDstQ102, LoadDstQ103,
        output IsLoadQ102, IsLoadQ103, SelNextPcBQ102, SelNextPcJQ102
    );

endinterface

//--- src/rv32Pkg.sv
package rv32Pkg;

    // Datapath widths
    localparam int XLEN     = 32;
    localparam int RegAddrW = 5;   // x0..x31

    // Instruction field positions (lsb of each field)
    localparam int RdLsb     = 7;
    localparam int Funct3Lsb = 12;
    localparam int Rs1Lsb    = 15;
    localparam int Rs2Lsb    = 20;
    localparam int Funct7Lsb = 25;

    // Major opcodes of RV32I
    typedef enum logic [6:0] {
        LOAD   = 7'b0000011,
        FENCE  = 7'b0001111,
        I_OP   = 7'b0010011,
        AUIPC  = 7'b0010111,
        STORE  = 7'b0100011,
        R_OP   = 7'b0110011,
        LUI    = 7'b0110111,
        BRANCH = 7'b1100011,
        JALR   = 7'b1100111,
        JAL    = 7'b1101111
    } tOpcode;

    typedef enum logic [3:0] {
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND
    } tAluOp;

    // Same encoding as funct3 of a branch
    typedef enum logic [2:0] {
        BEQ  = 3'b000,
        BNE  = 3'b001,
        BLT  = 3'b100,
        BGE  = 3'b101,
        BLTU = 3'b110,
        BGEU = 3'b111
    } tBranchOp;

    typedef enum logic [2:0] {
        I_TYPE, S_TYPE, B_TYPE, U_TYPE, J_TYPE
    } tImmType;

    localparam logic [XLEN-1:0] NopInst = 32'h0000_0013;  // addi x0, x0, 0

endpackage

//--- tb.f
src/rv32Pkg.sv
src/coreCtrlPkg.sv
src/pipeCtrlIf.sv
src/instDecoder.sv
src/hazardUnit.sv
src/ctrlPipe.sv
src/coreCtrl.sv
verif/coreCtrl_checker.sv
verif/coreCtrlTb.sv

//--- verif/coreCtrlTb.sv
module coreCtrlTb;
    import rv32Pkg::*;
    import coreCtrlPkg::*;

    localparam int TestLen   = 150;
    localparam int NumTests  = 6;
    localparam int MaxCycles = NumTests * TestLen * 3 + 300;   // Stalls and freezes included

    // Expected decode of one instruction word
    typedef struct packed {
        logic [31:0] imm;
        tAluOp       aluOp;
        logic        lui;
        logic        selAluPc;
        logic        selAluImm;
        logic        dmemWr;
        logic        dmemRd;
        logic [3:0]  byteEn;
        logic        signExt;
        tWbSel       wbSel;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic        regWr;
        logic        isLoad;
        logic        isJump;
        logic        isBranch;
        logic        usesRs2;
    } tExp;

    logic Clock = 1'b0;
    logic rstN = 1'b0;
    logic [31:0] PreInstructionQ101H = NopInst;
    logic BranchCondMetQ102H = 1'b0;
    logic DMemReady = 1'b1;
    logic ReadyQ100H, ReadyQ101H, ReadyQ102H;
    logic [4:0] RegSrc1Q101H, RegSrc2Q101H, RegDstQ105H;
    logic [31:0] ImmediateQ101H;
    logic SelNextPcAluOutQ102H, LuiQ102H, SelAluPcQ102H, SelAluImmQ102H;
    tAluOp AluOpQ102H;
    tBranchOp BranchOpQ102H;
    logic DMemWrEnQ103H, DMemRdEnQ103H, SignExtQ103H;
    logic [3:0] DMemByteEnQ103H;
    tWbSel SelWrBackQ105H;
    logic RegWrEnQ105H, ValidInstQ105H;

    integer seed = 32'h320b;
    int cycles = 0;
    int errors = 0;
    int checks = 0;
    int stalls = 0;
    int flushes = 0;
    int retired = 0;
    int freezeLeft = 0;
    string testName = "reset";
    bit checking = 1'b0;
    logic [4:0] loadDst = 5'd1;
    tOpcode opTable [10] = '{R_OP, I_OP, LUI, AUIPC, LOAD, STORE, BRANCH, JAL, JALR, FENCE};

    // Pipe model with index 0 as Q102
    logic [31:0] stWord [4];
    logic [3:0] stValid = '0;
    logic [3:0] stKnown = '0;   // Slot has held a real record since reset
    logic flushEcho = 1'b0;
    tExp e0, e1, e3, cur, slot;
    logic adv, flush, hazard, insertNop, expReady;
    logic [31:0] slotWord;

    coreCtrl dut (.*);

    always #5 Clock = ~Clock;

    always @(posedge Clock) begin
        cycles++;
        if (cycles >= MaxCycles) begin
            $display("Timeout: run stopped after %0d cycles", cycles);
            $display("=== FAIL ===");
            $finish;
        end
    end

    // ----------------------------------------
    // Reference decode
    // ----------------------------------------
    function automatic tExp refDecode(input logic [31:0] w);
        tExp e;
        logic [6:0] op;
        logic [2:0] f3;
        op = w[6:0];
        f3 = w[14:12];
        e = '0;
        e.rd = w[11:7];
        e.rs1 = w[19:15];
        e.rs2 = w[24:20];
        e.isLoad = (op == LOAD);
        e.isJump = (op == JAL) || (op == JALR);
        e.isBranch = (op == BRANCH);
        e.usesRs2 = (op == R_OP) || (op == STORE) || (op == BRANCH);
        e.lui = (op == LUI);
        e.selAluPc = (op == AUIPC) || (op == JAL) || (op == BRANCH);
        e.selAluImm = (op != R_OP);
        e.dmemWr = (op == STORE);
        e.dmemRd = e.isLoad;
        e.signExt = e.isLoad && (f3 == 3'b000 || f3 == 3'b001);   // LB, LH
        e.regWr = !(op == STORE || op == BRANCH || op == FENCE);
        e.wbSel = e.isJump ? WB_PC4 : (e.isLoad ? WB_DMEM : WB_ALU);
        e.aluOp = ADD;
        if (op == R_OP || op == I_OP) begin
            case (f3)
                3'b000: e.aluOp = (op == R_OP && w[30]) ? SUB : ADD;
                3'b001: e.aluOp = SLL;
                3'b010: e.aluOp = SLT;
                3'b011: e.aluOp = SLTU;
                3'b100: e.aluOp = XOR;
                3'b101: e.aluOp = w[30] ? SRA : SRL;
                3'b110: e.aluOp = OR;
                default: e.aluOp = AND;
            endcase
        end
        if (op == LOAD || op == STORE) begin
            case (f3[1:0])
                2'b00: e.byteEn = 4'b0001;
                2'b01: e.byteEn = 4'b0011;
                2'b10: e.byteEn = 4'b1111;
                default: e.byteEn = 4'b0000;
            endcase
        end
        case (op)
            STORE: e.imm = {{21{w[31]}}, w[30:25], w[11:7]};
            BRANCH: e.imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            LUI, AUIPC: e.imm = {w[31:12], 12'h000};
            JAL: e.imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            default: e.imm = {{21{w[31]}}, w[30:20]};
        endcase
        return e;
    endfunction

    function automatic logic loadHits(input logic v, input tExp st, input tExp q);
        return v && st.isLoad && (st.rd == q.rs1 || (q.usesRs2 && st.rd == q.rs2));
    endfunction

    // Class 0 ALU, 1 memory, 2 any, 3 load-use groups of four
    function automatic logic [31:0] randInst(input int cls, input int idx);
        logic [31:0] w;
        logic [2:0] f3;
        int r;
        tOpcode op;
        w = $random(seed);
        r = {$random(seed)} % 10;
        f3 = w[14:12];
        if (cls == 3) begin
            case (idx % 4)
                0, 2: begin   // LW with its base clear of the load before
                    w[19:15] = loadDst ^ 5'd1;
                    loadDst = 5'd1 + 5'({$random(seed)} % 31);
                    w = {w[31:15], 3'b010, loadDst, LOAD};
                end
                1: w = {w[31:20], loadDst, 3'b000, w[11:7], I_OP};      // Uses the load
                default: w = {w[31:20], loadDst ^ 5'd1, 3'b000, w[11:7], I_OP};  // Just misses
            endcase
            return w;
        end
        op = (cls == 0) ? opTable[r % 4] : (cls == 1) ? opTable[4 + r % 2] : opTable[r];
        w[6:0] = op;
        case (op)
            R_OP: w[31:25] = (f3 == 3'd0 || f3 == 3'd5) ? {1'b0, w[30], 5'b0} : 7'b0;
            I_OP: begin
                if (f3 == 3'd1) w[31:25] = 7'b0;
                else if (f3 == 3'd5) w[31:25] = {1'b0, w[30], 5'b0};
            end
            LOAD: if (f3 == 3'd3 || f3 >= 3'd6) w[14:12] = 3'b010;
            STORE: begin
                w[14] = 1'b0;
                if (w[13:12] == 2'b11) w[13:12] = 2'b10;
            end
            BRANCH: if (f3 == 3'd2 || f3 == 3'd3) w[14:12] = 3'b000;
            JALR, FENCE: w[14:12] = 3'b000;
            default: ;
        endcase
        return w;
    endfunction

    task automatic checkVal(input string what, input logic [31:0] expVal,
                            input logic [31:0] actVal);
        checks++;
        assert (actVal === expVal) else begin
            $display("** Error %s %s: expected %0h, actual %0h", testName, what, expVal, actVal);
            errors++;
        end
    endtask

    // ----------------------------------------
    // Compare after the falling-edge drive
    // ----------------------------------------
    always @(negedge Clock) begin
        #2;
        if (checking) begin
            e0 = refDecode(stWord[0]);
            e1 = refDecode(stWord[1]);
            e3 = refDecode(stWord[3]);
            cur = refDecode(PreInstructionQ101H);   // Raw fields drive the hazard check
            adv = DMemReady;
            flush = stValid[0] && (e0.isJump || (e0.isBranch && BranchCondMetQ102H));
            hazard = loadHits(stValid[0], e0, cur) || loadHits(stValid[1], e1, cur);
            insertNop = flush || flushEcho || hazard;
            expReady = adv && (flush || flushEcho || !hazard);
            slotWord = insertNop ? NopInst : PreInstructionQ101H;
            slot = refDecode(slotWord);
            checkVal("ReadyQ101H", expReady, ReadyQ101H);
            checkVal("ReadyQ100H", expReady, ReadyQ100H);
            checkVal("ReadyQ102H", adv, ReadyQ102H);
            checkVal("SelNextPcAluOutQ102H", flush, SelNextPcAluOutQ102H);
            checkVal("ImmediateQ101H", slot.imm, ImmediateQ101H);
            checkVal("RegSrc1Q101H", slot.rs1, RegSrc1Q101H);
            checkVal("RegSrc2Q101H", slot.rs2, RegSrc2Q101H);
            checkVal("ValidInstQ105H", stValid[3], ValidInstQ105H);
            if (stKnown[0]) begin
                checkVal("AluOpQ102H", e0.aluOp, AluOpQ102H);
                checkVal("BranchOpQ102H", stWord[0][14:12], BranchOpQ102H);
                checkVal("LuiQ102H", e0.lui, LuiQ102H);
                checkVal("SelAluPcQ102H", e0.selAluPc, SelAluPcQ102H);
                checkVal("SelAluImmQ102H", e0.selAluImm, SelAluImmQ102H);
            end
            if (stKnown[1]) begin
                checkVal("DMemWrEnQ103H", e1.dmemWr && stValid[1], DMemWrEnQ103H);
                checkVal("DMemRdEnQ103H", e1.dmemRd, DMemRdEnQ103H);
                checkVal("DMemByteEnQ103H", e1.byteEn, DMemByteEnQ103H);
                checkVal("SignExtQ103H", e1.signExt, SignExtQ103H);
            end
            if (stKnown[3]) begin
                checkVal("SelWrBackQ105H", e3.wbSel, SelWrBackQ105H);
                checkVal("RegDstQ105H", e3.rd, RegDstQ105H);
                checkVal("RegWrEnQ105H", e3.regWr && stValid[3], RegWrEnQ105H);
            end
            if (adv) begin   // Model steps with the DUT at the next rising edge
                if (!expReady) stalls++;
                if (flush) flushes++;
                if (stValid[3]) retired++;
                flushEcho = flush;
                for (int i = 3; i > 0; i--) begin
                    stWord[i] = stWord[i-1];
                    stValid[i] = stValid[i-1];
                    stKnown[i] = stKnown[i-1];
                end
                stWord[0] = slotWord;
                stValid[0] = expReady && !insertNop;
                stKnown[0] = 1'b1;
            end
        end
    end

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    task automatic runTest(input string name, input int cls, input int count,
                           input bit condOn, input bit freezeOn);
        int issued;
        int errBefore;
        int cycBefore;
        int stallBefore;
        int flushBefore;
        bit haveInst;
        logic [31:0] w;
        logic [31:0] rnd;
        testName = name;
        repeat (5) begin   // Empty the pipe so tests start clean
            @(negedge Clock);
            DMemReady = 1'b1;
            BranchCondMetQ102H = 1'b0;
            PreInstructionQ101H = NopInst;
        end
        errBefore = errors;
        cycBefore = cycles;
        stallBefore = stalls;
        flushBefore = flushes;
        issued = 0;
        haveInst = 1'b0;
        while (issued < count) begin
            @(negedge Clock);
            rnd = $random(seed);
            if (freezeOn && freezeLeft > 0) begin
                DMemReady = 1'b0;
                freezeLeft--;
            end else if (freezeOn && rnd[2:0] == 3'd0) begin
                DMemReady = 1'b0;              // Start of a memory wait span
                freezeLeft = rnd[5:4];
            end else begin
                DMemReady = 1'b1;
            end
            BranchCondMetQ102H = condOn & rnd[8];
            if (!haveInst) begin
                w = randInst(cls, issued);
                haveInst = 1'b1;
            end
            PreInstructionQ101H = w;
            #3;
            if (expReady) begin   // Fetch moves on once decode takes the word
                issued++;
                haveInst = 1'b0;
            end
        end
        if (cls == 3) begin   // Two per dependent, none for the near miss
            checkVal("stall cycles", 2 * ((count + 2) / 4), stalls - stallBefore);
        end
        if (condOn) begin
            assert (flushes > flushBefore) else begin
                $display("Test %s saw no taken branch or jump", name);
                errors++;
            end
        end
        $display("Test %-10s %0d instructions, %0d cycles, %0d errors",
                 name, count, cycles - cycBefore, errors - errBefore);
    endtask

    initial begin
        repeat (4) @(posedge Clock);
        @(negedge Clock);
        rstN = 1'b1;
        checking = 1'b1;
        runTest("aluDecode", 0, TestLen, 1'b0, 1'b0);
        runTest("memCtrl", 1, TestLen, 1'b0, 1'b0);
        runTest("writeBack", 2, TestLen, 1'b0, 1'b0);
        runTest("loadUse", 3, TestLen, 1'b0, 1'b0);
        runTest("flush", 2, TestLen, 1'b1, 1'b0);
        runTest("freeze", 2, TestLen, 1'b1, 1'b1);
        repeat (6) begin   // Let the last instructions reach Q105
            @(negedge Clock);
            DMemReady = 1'b1;
            BranchCondMetQ102H = 1'b0;
            PreInstructionQ101H = NopInst;
        end
        #4;
        errors += dut.propChecks.failures;
        $display("Tests: %0d, checks: %0d, retired: %0d, errors: %0d",
                 NumTests, checks, retired, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- verif/coreCtrl_checker.sv
module coreCtrl_checker (
    input logic Clock,
    input logic rstN,
    input logic ReadyQ100H,
    input logic ReadyQ101H,
    input logic ReadyQ102H,
    input logic DMemReady,
    input logic RegWrEnQ105H,
    input logic ValidInstQ105H
);

    int failures = 0;   // Read by the testbench at the end of the run

    // Fetch never runs ahead of decode
    fetchWithDecode: assert property (@(posedge Clock) disable iff (!rstN)
        ReadyQ100H |-> ReadyQ101H)
        else begin
            $error("ReadyQ100H high while ReadyQ101H low");
            failures++;
        end

    // Memory wait freezes the back end
    freezeOnMemWait: assert property (@(posedge Clock) disable iff (!rstN)
        !DMemReady |-> !ReadyQ102H)
        else begin
            $error("ReadyQ102H high while DMemReady low");
            failures++;
        end

    // A bubble never writes the register file
    writeNeedsValid: assert property (@(posedge Clock) disable iff (!rstN)
        RegWrEnQ105H |-> ValidInstQ105H)
        else begin
            $error("RegWrEnQ105H high without ValidInstQ105H");
            failures++;
        end

endmodule

bind coreCtrl coreCtrl_checker propChecks (
    .Clock          (Clock),
    .rstN           (rstN),
    .ReadyQ100H     (ReadyQ100H),
    .ReadyQ101H     (ReadyQ101H),
    .ReadyQ102H     (ReadyQ102H),
    .DMemReady      (DMemReady),
    .RegWrEnQ105H   (RegWrEnQ105H),
    .ValidInstQ105H (ValidInstQ105H)
);
